/* sim.f */
lsu_pkg.sv
store_align.sv
load_extend.sv
data_ram.sv
lsu_ctrl.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - store_align.sv
  - load_extend.sv
  - data_ram.sv
  - lsu_ctrl.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_asserts.sv
      - tb_lsu.sv

/* tb_lsu.sv */
`timescale 1ns/100ps

module tb_lsu;

    localparam int n_fill      = lsu_pkg::ram_depth;
    localparam int n_random    = 400;
    localparam int n_iso       = 40;    // store then ld, two requests each
    localparam int n_mis       = 30;    // misaligned then ld, two requests each
    localparam int n_requests  = n_fill + n_random + 2 * n_iso + 2 * n_mis;
    localparam int cycle_limit = n_requests * 8 + 50;
    localparam int mem_bytes   = 1 << lsu_pkg::addr_w;

    logic                clk;
    logic                reset;
    logic                req;
    lsu_pkg::mem_req_t   req_pkt;
    logic                ack;
    lsu_pkg::mem_rsp_t   rsp_pkt;

    logic [7:0]  model_mem [mem_bytes];   // byte model, little-endian lanes
    logic [31:0] rng_state;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    lsu_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .req_pkt (req_pkt),
        .ack     (ack),
        .rsp_pkt (rsp_pkt)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int op_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 1;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
            lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_sw: return 4;
            default:                                         return 8;
        endcase
    endfunction

    function automatic bit op_is_store(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw, lsu_pkg::op_sd};
    endfunction

    function automatic bit op_is_signed(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw};
    endfunction

    function automatic lsu_pkg::mem_op_e op_from_index(input int i);
        case (i)
            0:       return lsu_pkg::op_lb;
            1:       return lsu_pkg::op_lh;
            2:       return lsu_pkg::op_lw;
            3:       return lsu_pkg::op_ld;
            4:       return lsu_pkg::op_lbu;
            5:       return lsu_pkg::op_lhu;
            6:       return lsu_pkg::op_lwu;
            7:       return lsu_pkg::op_sb;
            8:       return lsu_pkg::op_sh;
            9:       return lsu_pkg::op_sw;
            default: return lsu_pkg::op_sd;
        endcase
    endfunction

    // expected load result from the byte model
    function automatic logic [63:0] model_load(input lsu_pkg::mem_op_e op, input int addr);
        logic [63:0] raw;
        int          size;
        bit          ext;
        size = op_size(op);
        raw  = '0;
        for (int i = 0; i < size; i++) begin
            raw[i*8 +: 8] = model_mem[addr + i];
        end
        ext = op_is_signed(op) && raw[size*8-1];
        for (int i = size; i < 8; i++) begin
            raw[i*8 +: 8] = ext ? 8'hff : 8'h00;
        end
        return raw;
    endfunction

    task automatic model_store(input lsu_pkg::mem_op_e op, input int addr,
                               input logic [63:0] wdata);
        for (int i = 0; i < op_size(op); i++) begin
            model_mem[addr + i] = wdata[i*8 +: 8];
        end
    endtask

    task automatic check_rsp(input string name, input lsu_pkg::mem_rsp_t got,
                             input lsu_pkg::mem_rsp_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected rdata=%h err=%h, got rdata=%h err=%h",
                     name, exp.rdata, exp.err, got.rdata, got.err);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // one four-phase transfer, entered and left just after a falling edge
    task automatic do_request(input lsu_pkg::mem_req_t pkt, input int hold,
                              output lsu_pkg::mem_rsp_t rsp);
        int edges;
        req_pkt = pkt;
        req     = 1'b1;
        edges   = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            check_bit("ack", ack, edges == 3);  // first edge is k
        end while (!ack && edges < 8);
        if (!ack) begin
            $display("no ack seen within %0d cycles of a request", edges);
            fail_count++;
        end
        rsp = rsp_pkt;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("ack held", ack, 1'b1);
            check_rsp("rsp_pkt held", rsp_pkt, rsp);
        end
        req = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("ack after release", ack, 1'b0);
    endtask

    task automatic run_op(input lsu_pkg::mem_op_e op, input int addr,
                          input logic [63:0] wdata, input int hold);
        lsu_pkg::mem_req_t pkt;
        lsu_pkg::mem_rsp_t exp_rsp;
        lsu_pkg::mem_rsp_t got_rsp;
        pkt.op    = op;
        pkt.addr  = addr[lsu_pkg::addr_w-1:0];
        pkt.wdata = wdata;
        exp_rsp   = '0;
        if (addr % op_size(op) != 0) begin
            exp_rsp.err = 1'b1;
        end else if (!op_is_store(op)) begin
            exp_rsp.rdata = model_load(op, addr);
        end
        do_request(pkt, hold, got_rsp);
        check_rsp($sformatf("rsp_pkt %s @%h", op.name(), addr), got_rsp, exp_rsp);
        if (op_is_store(op) && !exp_rsp.err) begin
            model_store(op, addr, wdata);
        end
    endtask

    task automatic report_test(input string name, input int p0, input int f0);
        $display("test %s finished: %0d checks passed, %0d failed",
                 name, pass_count - p0, fail_count - f0);
    endtask

    initial begin
        lsu_pkg::mem_rsp_t zero_rsp;
        lsu_pkg::mem_op_e  op;
        int                p0;
        int                f0;
        int                addr;
        int                size;
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        req_pkt     = '0;
        zero_rsp    = '0;
        rng_state   = 32'ha12be572;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;

        p0 = pass_count;
        f0 = fail_count;
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("ack in reset", ack, 1'b0);
            check_rsp("rsp_pkt in reset", rsp_pkt, zero_rsp);
        end
        reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("ack after reset", ack, 1'b0);
        check_rsp("rsp_pkt after reset", rsp_pkt, zero_rsp);
        report_test("reset", p0, f0);

        // RAM contents are unknown until every word is written
        p0 = pass_count;
        f0 = fail_count;
        for (int w = 0; w < n_fill; w++) begin
            run_op(lsu_pkg::op_sd, w * 8, {next_rand(), next_rand()}, 0);
        end
        report_test("fill", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int n = 0; n < n_random; n++) begin
            op   = op_from_index(next_rand() % 11);
            size = op_size(op);
            addr = next_rand() % mem_bytes;
            addr = addr - (addr % size);
            run_op(op, addr, {next_rand(), next_rand()}, next_rand() % 6);
        end
        report_test("random loads and stores", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int n = 0; n < n_iso; n++) begin
            op   = op_from_index(7 + next_rand() % 3);  // sb, sh or sw
            size = op_size(op);
            addr = next_rand() % mem_bytes;
            addr = addr - (addr % size);
            run_op(op, addr, {next_rand(), next_rand()}, next_rand() % 6);
            run_op(lsu_pkg::op_ld, addr - (addr % 8), '0, next_rand() % 6);
        end
        report_test("store isolation", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int n = 0; n < n_mis; n++) begin
            op   = op_from_index(1 + next_rand() % 10);  // anything wider than a byte
            if (op_size(op) == 1) begin
                op = lsu_pkg::op_sd;
            end
            size = op_size(op);
            addr = next_rand() % mem_bytes;
            addr = addr - (addr % size) + 1 + (next_rand() % (size - 1));
            run_op(op, addr, {next_rand(), next_rand()}, next_rand() % 6);
            run_op(lsu_pkg::op_ld, addr - (addr % 8), '0, next_rand() % 6);
        end
        report_test("misaligned", p0, f0);

        if (dut0.u_ctrl.u_asserts.fail_total != 0) begin
            $display("handshake checker flagged %0d assertion failures",
                     dut0.u_ctrl.u_asserts.fail_total);
            fail_count += dut0.u_ctrl.u_asserts.fail_total;
        end

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* lsu_asserts.sv */
`timescale 1ns/100ps

module lsu_asserts (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                ack,
    input  lsu_pkg::mem_rsp_t   rsp_pkt,
    input  lsu_pkg::ram_port_t  ram_cmd
);

    int fail_total;     // failed assertion count

    initial fail_total = 0;

    // ack is set at an edge that saw req high
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req)
    ) else begin
        $error("ack rose without req high");
        fail_total++;
    end

    // ack is cleared at an edge that saw req low
    ack_fall_needs_req_low: assert property (
        @(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req)
    ) else begin
        $error("ack fell while req was still high");
        fail_total++;
    end

    rsp_stable_during_ack: assert property (
        @(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(rsp_pkt)
    ) else begin
        $error("rsp_pkt changed while ack was high");
        fail_total++;
    end

    // a write with no lanes enabled means a bad opcode reached the RAM
    write_has_lanes: assert property (
        @(posedge clk) disable iff (reset)
        (ram_cmd.en && ram_cmd.we) |-> (ram_cmd.be != '0)
    ) else begin
        $error("RAM write with all-zero byte enable");
        fail_total++;
    end

endmodule

bind lsu_ctrl lsu_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .ack     (ack),
    .rsp_pkt (rsp_pkt),
    .ram_cmd (ram_cmd)
);

/* lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  lsu_pkg::mem_req_t   req_pkt,
    output logic                ack,
    output lsu_pkg::mem_rsp_t   rsp_pkt
);

    lsu_pkg::ram_port_t         ram_cmd;
    logic [lsu_pkg::be_w-1:0]   st_be;
    logic [lsu_pkg::data_w-1:0] st_word;
    logic [lsu_pkg::data_w-1:0] ram_rdata;
    logic [lsu_pkg::data_w-1:0] ld_value;
    lsu_pkg::mem_op_e           cur_op;
    logic [lsu_pkg::lane_w-1:0] cur_lane;
    logic [lsu_pkg::data_w-1:0] cur_wdata;

    lsu_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_pkt   (req_pkt),
        .ack       (ack),
        .rsp_pkt   (rsp_pkt),
        .ram_cmd   (ram_cmd),
        .st_be     (st_be),
        .st_word   (st_word),
        .ld_value  (ld_value),
        .cur_op    (cur_op),
        .cur_lane  (cur_lane),
        .cur_wdata (cur_wdata)
    );

    store_align u_store_align (
        .op    (cur_op),
        .lane  (cur_lane),
        .wdata (cur_wdata),
        .be    (st_be),
        .word  (st_word)
    );

    // read word is valid in st_resp, op and lane still held by the ctrl
    load_extend u_load_extend (
        .op    (cur_op),
        .lane  (cur_lane),
        .word  (ram_rdata),
        .value (ld_value)
    );

    data_ram u_ram (
        .clk   (clk),
        .cmd   (ram_cmd),
        .rdata (ram_rdata)
    );

endmodule

/* lsu_ctrl.sv */
`timescale 1ns/100ps

module lsu_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    input  lsu_pkg::mem_req_t           req_pkt,
    output logic                        ack,
    output lsu_pkg::mem_rsp_t           rsp_pkt,
    output lsu_pkg::ram_port_t          ram_cmd,
    input  logic [lsu_pkg::be_w-1:0]    st_be,
    input  logic [lsu_pkg::data_w-1:0]  st_word,
    input  logic [lsu_pkg::data_w-1:0]  ld_value,
    output lsu_pkg::mem_op_e            cur_op,
    output logic [lsu_pkg::lane_w-1:0]  cur_lane,
    output logic [lsu_pkg::data_w-1:0]  cur_wdata
);

    lsu_pkg::lsu_state_e        state;
    lsu_pkg::mem_req_t          cur_req;        // request held for the whole transfer
    logic                       cur_err;        // misaligned, memory untouched
    logic                       cur_store;
    logic [lsu_pkg::lane_w-1:0] align_mask;
    logic                       misaligned;
    logic                       ram_go;

    // address bits that must be zero for the access size
    always_comb begin
        case (req_pkt.op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: align_mask = 3'b000;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: align_mask = 3'b001;
            lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_sw: align_mask = 3'b011;
            default:                                         align_mask = 3'b111;
        endcase
    end

    assign misaligned = |(req_pkt.addr[lsu_pkg::lane_w-1:0] & align_mask);

    always_comb begin
        case (cur_req.op)
            lsu_pkg::op_sb,
            lsu_pkg::op_sh,
            lsu_pkg::op_sw,
            lsu_pkg::op_sd: cur_store = 1'b1;
            default:        cur_store = 1'b0;
        endcase
    end

    // payload capture at the request edge
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::st_idle && req) begin
            cur_req <= req_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= lsu_pkg::st_idle;
            cur_err <= 1'b0;
            ack     <= 1'b0;
            rsp_pkt <= '0;
        end else begin
            case (state)
                lsu_pkg::st_idle: begin
                    if (req) begin
                        cur_err <= misaligned;
                        state   <= lsu_pkg::st_access;
                    end
                end
                lsu_pkg::st_access: begin
                    state <= lsu_pkg::st_resp;  // ram writes or reads here
                end
                lsu_pkg::st_resp: begin
                    // stores and rejected accesses answer with zero data
                    rsp_pkt.rdata <= (cur_err || cur_store) ? '0 : ld_value;
                    rsp_pkt.err   <= cur_err;
                    ack           <= 1'b1;
                    state         <= lsu_pkg::st_hold;
                end
                lsu_pkg::st_hold: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= lsu_pkg::st_idle;
                    end
                end
                default: state <= lsu_pkg::st_idle;
            endcase
        end
    end

    assign ram_go = (state == lsu_pkg::st_access) && !cur_err;

    always_comb begin
        ram_cmd.en    = ram_go;
        ram_cmd.we    = ram_go && cur_store;
        ram_cmd.index = cur_req.addr[lsu_pkg::addr_w-1:lsu_pkg::lane_w];
        ram_cmd.be    = st_be;
        ram_cmd.wdata = st_word;
    end

    // captured fields out to the aligners
    assign cur_op    = cur_req.op;
    assign cur_lane  = cur_req.addr[lsu_pkg::lane_w-1:0];
    assign cur_wdata = cur_req.wdata;

endmodule

/* data_ram.sv */
`timescale 1ns/100ps

module data_ram (
    input  logic                        clk,
    input  lsu_pkg::ram_port_t          cmd,
    output logic [lsu_pkg::data_w-1:0]  rdata
);

    logic [lsu_pkg::data_w-1:0] mem [lsu_pkg::ram_depth];

    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.we) begin
                for (int b = 0; b < lsu_pkg::be_w; b++) begin
                    if (cmd.be[b]) begin
                        mem[cmd.index][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[cmd.index];    // holds while not enabled
            end
        end
    end

endmodule

/* load_extend.sv */
`timescale 1ns/100ps

module load_extend (
    input  lsu_pkg::mem_op_e            op,
    input  logic [lsu_pkg::lane_w-1:0]  lane,
    input  logic [lsu_pkg::data_w-1:0]  word,
    output logic [lsu_pkg::data_w-1:0]  value
);

    logic [lsu_pkg::data_w-1:0] shifted;    // addressed lane moved to byte 0

    assign shifted = word >> {lane, 3'b000};

    always_comb begin
        case (op)
            lsu_pkg::op_lb:  value = {{56{shifted[7]}}, shifted[7:0]};
            lsu_pkg::op_lh:  value = {{48{shifted[15]}}, shifted[15:0]};
            lsu_pkg::op_lw:  value = {{32{shifted[31]}}, shifted[31:0]};
            lsu_pkg::op_ld:  value = word;
            lsu_pkg::op_lbu: value = {56'd0, shifted[7:0]};
            lsu_pkg::op_lhu: value = {48'd0, shifted[15:0]};
            lsu_pkg::op_lwu: value = {32'd0, shifted[31:0]};
            default:         value = '0;    // stores return nothing
        endcase
    end

endmodule

/* store_align.sv */
`timescale 1ns/100ps

module store_align (
    input  lsu_pkg::mem_op_e            op,
    input  logic [lsu_pkg::lane_w-1:0]  lane,
    input  logic [lsu_pkg::data_w-1:0]  wdata,
    output logic [lsu_pkg::be_w-1:0]    be,
    output logic [lsu_pkg::data_w-1:0]  word
);

    logic [lsu_pkg::be_w-1:0]   size_be;    // mask as if lane were 0
    logic [lsu_pkg::data_w-1:0] size_bits;  // same mask, one bit per data bit

    always_comb begin
        case (op)
            lsu_pkg::op_sb: size_be = 8'h01;
            lsu_pkg::op_sh: size_be = 8'h03;
            lsu_pkg::op_sw: size_be = 8'h0f;
            lsu_pkg::op_sd: size_be = 8'hff;
            default:        size_be = 8'h00;    // loads write nothing
        endcase
    end

    always_comb begin
        for (int b = 0; b < lsu_pkg::be_w; b++) begin
            size_bits[b*8 +: 8] = {8{size_be[b]}};
        end
    end

    // alignment is checked upstream, so the shifted mask never wraps
    assign be   = size_be << lane;
    assign word = (wdata & size_bits) << {lane, 3'b000};

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    localparam int data_w    = 64;
    localparam int addr_w    = 11;              // 2 KiB data memory
    localparam int ram_depth = 256;
    localparam int lane_w    = 3;
    localparam int be_w      = data_w / 8;      // one enable per byte lane
    localparam int idx_w     = addr_w - lane_w; // word index into the RAM

    // bit 3 marks a store, bit 2 an unsigned load
    // low two bits give the size: 00 word, 01 byte, 10 half, 11 double
    typedef enum logic [3:0] {
        op_lw  = 4'b0000,
        op_lb  = 4'b0001,
        op_lh  = 4'b0010,
        op_ld  = 4'b0011,
        op_lwu = 4'b0100,
        op_lbu = 4'b0101,
        op_lhu = 4'b0110,
        op_sw  = 4'b1000,
        op_sb  = 4'b1001,
        op_sh  = 4'b1010,
        op_sd  = 4'b1011
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,   // waiting for req
        st_access = 2'd1,   // ram port active
        st_resp   = 2'd2,   // response being registered
        st_hold   = 2'd3    // ack high, waiting for req to drop
    } lsu_state_e;

    // core side request, held stable while req is high
    typedef struct packed {
        mem_op_e           op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              err;     // misaligned access
    } mem_rsp_t;

    // command into the data RAM
    typedef struct packed {
        logic              en;
        logic              we;
        logic [idx_w-1:0]  index;
        logic [be_w-1:0]   be;
        logic [data_w-1:0] wdata;
    } ram_port_t;

endpackage
